/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal -j 0
TOP       := tb_depar
FILELIST  := tb.f

SRCS := $(shell grep -v '^+' $(FILELIST))
HDRS := $(wildcard verif/*.svh)
BIN  := obj_dir/V$(TOP)
PASS := Finished with no errors

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^$(PASS)$$"

clean:
	rm -rf obj_dir

/* hdl/depar_action_pkg.sv */
package depar_action_pkg;

	localparam int ACTION_W = 16;

	// bit 0 is valid and bits 15..13 are unused
	typedef struct packed {
		logic [2:0] unused;
		logic [6:0] offset;
		logic [1:0] ctype;
		logic [2:0] idx;
		logic       valid;
	} action_t;

	localparam logic [1:0] CT_NONE = 2'b00;
	localparam logic [1:0] CT_2B   = 2'b01;
	localparam logic [1:0] CT_4B   = 2'b10;
	localparam logic [1:0] CT_6B   = 2'b11;

	// containers of each size
	localparam int NUM_CONT = 8;
	localparam int C2_BASE  = 0;
	localparam int C4_BASE  = C2_BASE + NUM_CONT * 16;
	localparam int C6_BASE  = C4_BASE + NUM_CONT * 32;
	localparam int PHV_W    = C6_BASE + NUM_CONT * 48;

	typedef logic [PHV_W-1:0] phv_t;
	typedef logic [47:0] field_t; // right-justified

	localparam int RAM_ADDR_W = 5;
	localparam int TBL_IDX_LO = 4; // vlan id bits 8..4

	localparam int CTRL_MOD_ID_BYTE = 14;
	localparam int CTRL_ADDR_BYTE   = 16;

endpackage

/* hdl/depar_action_ram.sv */
`timescale 1ns/10ps

module depar_action_ram #(
	parameter int NUM_ACTIONS = 4
) (
	input  logic                                              clk,
	input  logic                                              tbl_wr_en,
	input  logic [depar_action_pkg::RAM_ADDR_W-1:0]           tbl_wr_addr,
	input  logic [NUM_ACTIONS*depar_action_pkg::ACTION_W-1:0] tbl_wr_entry,
	input  logic [depar_stream_pkg::VLAN_W-1:0]               vlan_id,
	output logic [NUM_ACTIONS*depar_action_pkg::ACTION_W-1:0] ram_entry
);

	localparam int ENTRY_W = NUM_ACTIONS * depar_action_pkg::ACTION_W;
	localparam int DEPTH   = 2 ** depar_action_pkg::RAM_ADDR_W;

	logic [ENTRY_W-1:0] mem [0:DEPTH-1];

	initial begin
		for (int i = 0; i < DEPTH; i++) begin
			mem[i] = '0;
		end
	end

	always_ff @(posedge clk) begin
		if (tbl_wr_en) mem[tbl_wr_addr] <= tbl_wr_entry;
		ram_entry <= mem[vlan_id[depar_action_pkg::TBL_IDX_LO +: depar_action_pkg::RAM_ADDR_W]];
	end

endmodule

/* hdl/depar_cfg_loader.sv */
`timescale 1ns/10ps

module depar_cfg_loader #(
	parameter int         NUM_ACTIONS = 4,
	parameter logic [2:0] MOD_ID      = 3'd5
) (
	input  logic                                              clk,
	input  logic                                              aresetn,
	input  depar_stream_pkg::data_t                           ctrl_tdata,
	input  logic                                              ctrl_tvalid,
	input  logic                                              ctrl_tlast,
	output logic                                              tbl_wr_en,
	output logic [depar_action_pkg::RAM_ADDR_W-1:0]           tbl_wr_addr,
	output logic [NUM_ACTIONS*depar_action_pkg::ACTION_W-1:0] tbl_wr_entry
);

	localparam int ENTRY_W     = NUM_ACTIONS * depar_action_pkg::ACTION_W;
	localparam int ENTRY_BYTES = ENTRY_W / 8;

	typedef enum logic [1:0] {WAIT_B0, WAIT_B1, WAIT_B2, SKIP} state_t;

	state_t             state;
	logic               id_match;
	logic [ENTRY_W-1:0] beat_entry;

	assign id_match = (ctrl_tdata[depar_action_pkg::CTRL_MOD_ID_BYTE*8 +: 3] == MOD_ID);

	// byte 0 of beat 2 is the top byte of the entry
	always_comb begin
		for (int k = 0; k < ENTRY_BYTES; k++) begin
			beat_entry[(ENTRY_BYTES-1-k)*8 +: 8] = ctrl_tdata[k*8 +: 8];
		end
	end

	always_ff @(posedge clk) begin
		if (!aresetn) begin
			state     <= WAIT_B0;
			tbl_wr_en <= 1'b0;
		end else begin
			tbl_wr_en <= 1'b0;
			if (ctrl_tvalid) begin
				case (state)
					WAIT_B0: if (!ctrl_tlast) state <= WAIT_B1;
					WAIT_B1: begin
						if (ctrl_tlast) state <= WAIT_B0; // too short to carry an entry
						else if (id_match) state <= WAIT_B2;
						else state <= SKIP;
					end
					WAIT_B2: begin
						tbl_wr_en <= 1'b1;
						state     <= ctrl_tlast ? WAIT_B0 : SKIP;
					end
					default: if (ctrl_tlast) state <= WAIT_B0;
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (ctrl_tvalid && state == WAIT_B1)
			tbl_wr_addr <= ctrl_tdata[depar_action_pkg::CTRL_ADDR_BYTE*8 +:
				depar_action_pkg::RAM_ADDR_W];
		if (ctrl_tvalid && state == WAIT_B2)
			tbl_wr_entry <= beat_entry;
	end

endmodule

/* hdl/depar_ctrl.sv */
`timescale 1ns/10ps

module depar_ctrl #(
	parameter int NUM_ACTIONS = 4
) (
	input  logic                                          clk,
	input  logic                                          aresetn,
	input  logic                                          vlan_empty,
	input  logic                                          phv_empty,
	input  logic                                          hdr_empty,
	input  logic                                          pkt_empty,
	input  logic [NUM_ACTIONS*depar_action_pkg::ACTION_W-1:0] ram_entry,
	input  logic                                          out_tlast,
	input  logic                                          depar_out_tready,
	output logic                                          vlan_rd_en,
	output logic                                          phv_rd_en,
	output logic                                          hdr_rd_en,
	output logic                                          pkt_rd_en,
	output logic                                          hdr_load,
	output logic                                          patch_en,
	output depar_action_pkg::action_t                     cur_action,
	output depar_stream_pkg::beat_sel_t                   beat_sel,
	output logic                                          depar_out_tvalid
);

	localparam int CNT_W = (NUM_ACTIONS > 1) ? $clog2(NUM_ACTIONS) : 1;
	localparam int ACT_W = depar_action_pkg::ACTION_W;

	typedef enum logic [2:0] {IDLE, WAIT_RAM, LOAD, PATCH, FLUSH0, FLUSH1, PASS} state_t;

	state_t           state;
	logic [CNT_W-1:0] act_cnt;
	logic             last_act;
	logic             hdr_ready;
	logic             xfer;

	assign last_act  = (act_cnt == CNT_W'(NUM_ACTIONS - 1));
	assign hdr_ready = !phv_empty && !hdr_empty;
	assign xfer      = depar_out_tvalid && depar_out_tready;

	// action 0 sits in the top slot
	assign cur_action = ram_entry[(NUM_ACTIONS - 1 - act_cnt) * ACT_W +: ACT_W];

	always_ff @(posedge clk) begin
		if (!aresetn) begin
			state   <= IDLE;
			act_cnt <= '0;
		end else begin
			case (state)
				IDLE: if (!vlan_empty) state <= WAIT_RAM;
				WAIT_RAM: state <= LOAD; // ram read latency
				LOAD: begin
					act_cnt <= '0;
					if (hdr_ready) state <= PATCH;
				end
				PATCH: begin
					act_cnt <= act_cnt + 1'b1;
					if (last_act) state <= FLUSH0;
				end
				FLUSH0: if (xfer) state <= out_tlast ? IDLE : FLUSH1;
				FLUSH1: if (xfer) state <= out_tlast ? IDLE : PASS;
				PASS: if (xfer && out_tlast) state <= IDLE;
				default: state <= IDLE;
			endcase
		end
	end

	always_comb begin
		vlan_rd_en       = 1'b0;
		phv_rd_en        = 1'b0;
		hdr_rd_en        = 1'b0;
		pkt_rd_en        = 1'b0;
		hdr_load         = 1'b0;
		patch_en         = 1'b0;
		depar_out_tvalid = 1'b0;
		beat_sel         = depar_stream_pkg::SEL_BEAT0;
		case (state)
			LOAD: hdr_load = hdr_ready;
			PATCH: begin
				patch_en   = cur_action.valid;
				vlan_rd_en = last_act; // pop once on the last action
				phv_rd_en  = last_act;
				hdr_rd_en  = last_act;
			end
			FLUSH0: depar_out_tvalid = 1'b1;
			FLUSH1: begin
				depar_out_tvalid = 1'b1;
				beat_sel         = depar_stream_pkg::SEL_BEAT1;
			end
			PASS: begin
				beat_sel         = depar_stream_pkg::SEL_PASS;
				depar_out_tvalid = !pkt_empty;
				pkt_rd_en        = !pkt_empty && depar_out_tready;
			end
			default: ;
		endcase
	end

endmodule

/* hdl/depar_field_extract.sv */
`timescale 1ns/10ps

module depar_field_extract (
	input  depar_action_pkg::phv_t    phv,
	input  depar_action_pkg::action_t cur_action,
	output depar_action_pkg::field_t  field_bytes
);

	logic [2:0] idx;

	assign idx = cur_action.idx;

	always_comb begin
		field_bytes = '0;
		case (cur_action.ctype)
			depar_action_pkg::CT_2B: begin
				field_bytes[15:0] = phv[depar_action_pkg::C2_BASE + 16*idx +: 16];
			end
			depar_action_pkg::CT_4B: begin
				field_bytes[31:0] = phv[depar_action_pkg::C4_BASE + 32*idx +: 32];
			end
			depar_action_pkg::CT_6B: begin
				field_bytes = phv[depar_action_pkg::C6_BASE + 48*idx +: 48];
			end
			depar_action_pkg::CT_NONE: field_bytes = '0; // no container
			default: field_bytes = '0;
		endcase
	end

endmodule

/* hdl/depar_hdr_buf.sv */
`timescale 1ns/10ps

module depar_hdr_buf (
	input  logic                        clk,
	input  logic                        aresetn,
	input  logic                        hdr_load,
	input  depar_stream_pkg::hdr_data_t hdr_tdata,
	input  depar_stream_pkg::hdr_keep_t hdr_tkeep,
	input  logic [1:0]                  hdr_tlast,
	input  logic                        patch_en,
	input  depar_action_pkg::action_t   cur_action,
	input  depar_action_pkg::field_t    field_bytes,
	input  depar_stream_pkg::beat_sel_t beat_sel,
	input  depar_stream_pkg::data_t     pkt_tdata,
	input  depar_stream_pkg::keep_t     pkt_tkeep,
	input  logic                        pkt_tlast,
	output depar_stream_pkg::data_t     out_tdata,
	output depar_stream_pkg::keep_t     out_tkeep,
	output logic                        out_tlast
);

	localparam int DATA_W = depar_stream_pkg::DATA_W;
	localparam int KEEP_W = depar_stream_pkg::KEEP_W;

	depar_stream_pkg::hdr_data_t hdr_data;
	depar_stream_pkg::hdr_data_t patched;
	depar_stream_pkg::hdr_keep_t hdr_keep;
	logic [1:0]                  hdr_last;

	// most significant field byte lands at the offset
	always_comb begin
		int len;
		int pos;
		case (cur_action.ctype)
			depar_action_pkg::CT_2B: len = 2;
			depar_action_pkg::CT_4B: len = 4;
			depar_action_pkg::CT_6B: len = 6;
			default: len = 0;
		endcase
		patched = hdr_data;
		for (int j = 0; j < 6; j++) begin
			pos = int'(cur_action.offset) + j;
			if (j < len && pos < 2*KEEP_W)
				patched[pos*8 +: 8] = field_bytes[(len-1-j)*8 +: 8];
		end
	end

	always_ff @(posedge clk) begin
		if (hdr_load) begin
			hdr_data <= hdr_tdata;
			hdr_keep <= hdr_tkeep;
		end else if (patch_en) begin
			hdr_data <= patched;
		end
	end

	always_ff @(posedge clk) begin
		if (!aresetn) hdr_last <= 2'b00;
		else if (hdr_load) hdr_last <= hdr_tlast;
	end

	always_comb begin
		case (beat_sel)
			depar_stream_pkg::SEL_BEAT0: begin
				out_tdata = hdr_data[0 +: DATA_W];
				out_tkeep = hdr_keep[0 +: KEEP_W];
				out_tlast = hdr_last[0];
			end
			depar_stream_pkg::SEL_BEAT1: begin
				out_tdata = hdr_data[DATA_W +: DATA_W];
				out_tkeep = hdr_keep[KEEP_W +: KEEP_W];
				out_tlast = hdr_last[1];
			end
			default: begin // packet fifo pass-through
				out_tdata = pkt_tdata;
				out_tkeep = pkt_tkeep;
				out_tlast = pkt_tlast;
			end
		endcase
	end

endmodule

/* hdl/depar_stream_pkg.sv */
package depar_stream_pkg;

	localparam int DATA_W = 256;
	localparam int KEEP_W = DATA_W / 8;
	localparam int VLAN_W = 12;

	typedef logic [DATA_W-1:0] data_t;
	typedef logic [KEEP_W-1:0] keep_t;

	// beat 0 in the low half with byte 0 in the lowest bits
	typedef logic [2*DATA_W-1:0] hdr_data_t;
	typedef logic [2*KEEP_W-1:0] hdr_keep_t;

	// output source
	typedef enum logic [1:0] {
		SEL_BEAT0 = 2'd0,
		SEL_BEAT1 = 2'd1,
		SEL_PASS  = 2'd2
	} beat_sel_t;

endpackage

/* hdl/depar_top.sv */
`timescale 1ns/10ps

module depar_top #(
	parameter int         NUM_ACTIONS = 4,
	parameter logic [2:0] MOD_ID      = 3'd5
) (
	input  logic                                clk,
	input  logic                                aresetn,
	input  logic [depar_stream_pkg::VLAN_W-1:0] vlan_id,
	input  logic                                vlan_empty,
	output logic                                vlan_rd_en,
	input  depar_action_pkg::phv_t              phv,
	input  logic                                phv_empty,
	output logic                                phv_rd_en,
	input  depar_stream_pkg::hdr_data_t         hdr_tdata,
	input  depar_stream_pkg::hdr_keep_t         hdr_tkeep,
	input  logic [1:0]                          hdr_tlast,
	input  logic                                hdr_empty,
	output logic                                hdr_rd_en,
	input  depar_stream_pkg::data_t             pkt_tdata,
	input  depar_stream_pkg::keep_t             pkt_tkeep,
	input  logic                                pkt_tlast,
	input  logic                                pkt_empty,
	output logic                                pkt_rd_en,
	output depar_stream_pkg::data_t             depar_out_tdata,
	output depar_stream_pkg::keep_t             depar_out_tkeep,
	output logic                                depar_out_tlast,
	output logic                                depar_out_tvalid,
	input  logic                                depar_out_tready,
	input  depar_stream_pkg::data_t             ctrl_tdata,
	input  logic                                ctrl_tvalid,
	input  logic                                ctrl_tlast
);

	localparam int ENTRY_W = NUM_ACTIONS * depar_action_pkg::ACTION_W;

	logic [ENTRY_W-1:0]                   ram_entry;
	logic [ENTRY_W-1:0]                   tbl_wr_entry;
	logic [depar_action_pkg::RAM_ADDR_W-1:0] tbl_wr_addr;
	logic                                 tbl_wr_en;
	logic                                 hdr_load;
	logic                                 patch_en;
	depar_action_pkg::action_t            cur_action;
	depar_action_pkg::field_t             field_bytes;
	depar_stream_pkg::beat_sel_t          beat_sel;

	depar_ctrl #(
		.NUM_ACTIONS (NUM_ACTIONS)
	) depar_ctrl_i (
		.clk              (clk),
		.aresetn          (aresetn),
		.vlan_empty       (vlan_empty),
		.phv_empty        (phv_empty),
		.hdr_empty        (hdr_empty),
		.pkt_empty        (pkt_empty),
		.ram_entry        (ram_entry),
		.out_tlast        (depar_out_tlast),
		.depar_out_tready (depar_out_tready),
		.vlan_rd_en       (vlan_rd_en),
		.phv_rd_en        (phv_rd_en),
		.hdr_rd_en        (hdr_rd_en),
		.pkt_rd_en        (pkt_rd_en),
		.hdr_load         (hdr_load),
		.patch_en         (patch_en),
		.cur_action       (cur_action),
		.beat_sel         (beat_sel),
		.depar_out_tvalid (depar_out_tvalid)
	);

	depar_cfg_loader #(
		.NUM_ACTIONS (NUM_ACTIONS),
		.MOD_ID      (MOD_ID)
	) depar_cfg_loader_i (
		.clk          (clk),
		.aresetn      (aresetn),
		.ctrl_tdata   (ctrl_tdata),
		.ctrl_tvalid  (ctrl_tvalid),
		.ctrl_tlast   (ctrl_tlast),
		.tbl_wr_en    (tbl_wr_en),
		.tbl_wr_addr  (tbl_wr_addr),
		.tbl_wr_entry (tbl_wr_entry)
	);

	depar_action_ram #(
		.NUM_ACTIONS (NUM_ACTIONS)
	) depar_action_ram_i (
		.clk          (clk),
		.tbl_wr_en    (tbl_wr_en),
		.tbl_wr_addr  (tbl_wr_addr),
		.tbl_wr_entry (tbl_wr_entry),
		.vlan_id      (vlan_id),
		.ram_entry    (ram_entry)
	);

	depar_field_extract depar_field_extract_i (
		.phv         (phv),
		.cur_action  (cur_action),
		.field_bytes (field_bytes)
	);

	depar_hdr_buf depar_hdr_buf_i (
		.clk         (clk),
		.aresetn     (aresetn),
		.hdr_load    (hdr_load),
		.hdr_tdata   (hdr_tdata),
		.hdr_tkeep   (hdr_tkeep),
		.hdr_tlast   (hdr_tlast),
		.patch_en    (patch_en),
		.cur_action  (cur_action),
		.field_bytes (field_bytes),
		.beat_sel    (beat_sel),
		.pkt_tdata   (pkt_tdata),
		.pkt_tkeep   (pkt_tkeep),
		.pkt_tlast   (pkt_tlast),
		.out_tdata   (depar_out_tdata),
		.out_tkeep   (depar_out_tkeep),
		.out_tlast   (depar_out_tlast)
	);

endmodule

/* tb.f */
+incdir+verif
hdl/depar_stream_pkg.sv
hdl/depar_action_pkg.sv
hdl/depar_field_extract.sv
hdl/depar_hdr_buf.sv
hdl/depar_action_ram.sv
hdl/depar_cfg_loader.sv
hdl/depar_ctrl.sv
hdl/depar_top.sv
verif/tb_depar.sv

/* verif/tb_depar_tasks.svh */
task automatic fail_run(input string msg);
	$display("%s", msg);
	$display("Finished with errors");
	$fatal(1);
endtask

task automatic compare_data(input string name, input depar_stream_pkg::data_t got,
	input depar_stream_pkg::data_t want);
	if (got !== want)
		fail_run($sformatf("mismatch %s: got %h, expected %h", name, got, want));
endtask

task automatic compare_keep(input string name, input depar_stream_pkg::keep_t got,
	input depar_stream_pkg::keep_t want);
	if (got !== want)
		fail_run($sformatf("mismatch %s: got %h, expected %h", name, got, want));
endtask

task automatic compare_last(input string name, input logic got, input logic want);
	if (got !== want)
		fail_run($sformatf("mismatch %s: got %h, expected %h", name, got, want));
endtask

task automatic pop_fifos();
	if (vlan_rd_en) void'(vlan_q.pop_front());
	if (phv_rd_en) void'(phv_q.pop_front());
	if (hdr_rd_en) begin
		void'(hdr_data_q.pop_front());
		void'(hdr_keep_q.pop_front());
		void'(hdr_last_q.pop_front());
	end
	if (pkt_rd_en) begin
		void'(pkt_data_q.pop_front());
		void'(pkt_keep_q.pop_front());
		void'(pkt_last_q.pop_front());
	end
endtask

task automatic check_beat();
	if (exp_data_q.size() == 0)
		fail_run("output beat transferred while none was expected");
	else begin
		compare_data("depar_out_tdata", depar_out_tdata, exp_data_q.pop_front());
		compare_keep("depar_out_tkeep", depar_out_tkeep, exp_keep_q.pop_front());
		compare_last("depar_out_tlast", depar_out_tlast, exp_last_q.pop_front());
	end
endtask

function automatic depar_action_pkg::action_t mk_act(input bit v, input bit [1:0] ct,
	input bit [2:0] idx, input bit [6:0] off);
	return {3'b000, off, ct, idx, v};
endfunction

function automatic depar_stream_pkg::data_t rand_data();
	depar_stream_pkg::data_t d;
	for (int i = 0; i < 8; i++) d[i*32 +: 32] = $urandom;
	return d;
endfunction

// container bytes go msb first at the offset within the 64 header bytes
function automatic depar_stream_pkg::hdr_data_t apply_action(
	input depar_stream_pkg::hdr_data_t hdr, input depar_action_pkg::action_t act,
	input depar_action_pkg::phv_t phv_in);
	int len;
	int base;
	depar_stream_pkg::hdr_data_t res;
	res = hdr;
	len = (act.ctype == 2'b00) ? 0 : 2 * int'(act.ctype);
	case (act.ctype)
		2'b01: base = 16 * int'(act.idx);
		2'b10: base = 128 + 32 * int'(act.idx);
		default: base = 384 + 48 * int'(act.idx);
	endcase
	for (int j = 0; j < len; j++) begin
		if (act.valid && int'(act.offset) + j < 64)
			res[(int'(act.offset) + j)*8 +: 8] = phv_in[base + (len-1-j)*8 +: 8];
	end
	return res;
endfunction

task automatic new_stimulus(input int n_pay);
	for (int i = 0; i < 24; i++) stim_phv[i*32 +: 32] = $urandom;
	stim_hdr  = {rand_data(), rand_data()};
	stim_keep = '1;
	for (int i = 0; i < n_pay; i++) begin
		pay_data[i] = rand_data();
		pay_keep[i] = (i == n_pay - 1) ? depar_stream_pkg::keep_t'($urandom) : '1;
	end
endtask

task automatic program_entry(input logic [2:0] mod_id, input logic [4:0] addr,
	input depar_action_pkg::action_t a0, input depar_action_pkg::action_t a1,
	input depar_action_pkg::action_t a2, input depar_action_pkg::action_t a3);
	logic [63:0] entry;
	depar_stream_pkg::data_t beat;
	entry = {a0, a1, a2, a3};
	@(negedge clk);
	ctrl_tdata  = rand_data();
	ctrl_tvalid = 1'b1;
	@(negedge clk);
	beat = rand_data();
	beat[depar_action_pkg::CTRL_MOD_ID_BYTE*8 +: 8] = {5'($urandom), mod_id};
	beat[depar_action_pkg::CTRL_ADDR_BYTE*8 +: 8]   = {3'($urandom), addr};
	ctrl_tdata = beat;
	@(negedge clk);
	beat = rand_data();
	for (int k = 0; k < 8; k++) beat[k*8 +: 8] = entry[(7-k)*8 +: 8]; // byte 0 is msb
	ctrl_tdata = beat;
	ctrl_tlast = 1'b1;
	@(negedge clk);
	ctrl_tvalid = 1'b0;
	ctrl_tlast  = 1'b0;
	if (mod_id == MOD_ID) shadow_tbl[addr] = entry;
	repeat (2) @(negedge clk);
endtask

task automatic send_packet(input logic [11:0] vlan, input logic [1:0] hlast, input int n_pay);
	logic [63:0] entry;
	depar_stream_pkg::hdr_data_t want;
	entry = shadow_tbl[vlan[8:4]];
	want  = stim_hdr;
	for (int i = 0; i < 4; i++) want = apply_action(want, entry[(3-i)*16 +: 16], stim_phv);
	vlan_q.push_back(vlan);
	phv_q.push_back(stim_phv);
	hdr_data_q.push_back(stim_hdr);
	hdr_keep_q.push_back(stim_keep);
	hdr_last_q.push_back(hlast);
	exp_data_q.push_back(want[255:0]);
	exp_keep_q.push_back(stim_keep[31:0]);
	exp_last_q.push_back(hlast[0]);
	if (!hlast[0]) begin
		exp_data_q.push_back(want[511:256]);
		exp_keep_q.push_back(stim_keep[63:32]);
		exp_last_q.push_back(hlast[1]);
	end
	for (int i = 0; i < n_pay && hlast == 2'b00; i++) begin
		pkt_data_q.push_back(pay_data[i]);
		pkt_keep_q.push_back(pay_keep[i]);
		pkt_last_q.push_back(i == n_pay - 1);
		exp_data_q.push_back(pay_data[i]);
		exp_keep_q.push_back(pay_keep[i]);
		exp_last_q.push_back(i == n_pay - 1);
	end
endtask

task automatic wait_drain();
	while (exp_data_q.size() != 0) @(negedge clk);
	repeat (2) @(negedge clk);
	if (vlan_q.size() != 0 || phv_q.size() != 0 || hdr_data_q.size() != 0 ||
			pkt_data_q.size() != 0)
		fail_run("input FIFOs still hold data after the packets went out");
endtask

task automatic test_field_sizes();
	program_entry(MOD_ID, 5'd1, mk_act(1, 2'b01, 3, 2), mk_act(1, 2'b10, 5, 10),
		mk_act(1, 2'b11, 7, 20), mk_act(0, 2'b00, 0, 0));
	new_stimulus(0);
	stim_keep[31:0] = 32'h0fff_ffff;
	send_packet(12'h01a, 2'b01, 0);
	wait_drain();
endtask

task automatic test_unused_foreign();
	program_entry(MOD_ID, 5'd2, mk_act(1, 2'b11, 0, 40), mk_act(0, 2'b10, 1, 0),
		mk_act(1, 2'b01, 6, 62), mk_act(1, 2'b10, 2, 33));
	new_stimulus(0);
	send_packet(12'h02b, 2'b10, 0);
	wait_drain();
	// entry 2 keeps its contents under another module id
	program_entry(3'd3, 5'd2, mk_act(1, 2'b11, 4, 0), mk_act(1, 2'b10, 3, 8),
		mk_act(1, 2'b01, 1, 16), mk_act(1, 2'b10, 0, 24));
	new_stimulus(0);
	send_packet(12'he2c, 2'b10, 0);
	wait_drain();
endtask

task automatic test_full_packet();
	program_entry(MOD_ID, 5'd9, mk_act(1, 2'b01, 1, 0), mk_act(1, 2'b11, 3, 29),
		mk_act(1, 2'b01, 4, 45), mk_act(1, 2'b10, 6, 50));
	new_stimulus(3);
	send_packet(12'h095, 2'b00, 3);
	wait_drain();
endtask

task automatic test_back_pressure();
	bp_on = 1'b1; // same stimulus as the full packet test
	send_packet(12'h095, 2'b00, 3);
	wait_drain();
	bp_on = 1'b0;
endtask

task automatic test_back_to_back();
	program_entry(MOD_ID, 5'd20, mk_act(1, 2'b10, 7, 4), mk_act(1, 2'b11, 2, 12),
		mk_act(0, 2'b01, 0, 0), mk_act(1, 2'b01, 5, 31));
	new_stimulus(0);
	send_packet(12'h345, 2'b01, 0);
	new_stimulus(1);
	send_packet(12'h09f, 2'b00, 1);
	wait_drain();
endtask

/* verif/tb_depar.sv */
`timescale 1ns/10ps

module tb_depar;

	localparam int         NUM_ACTIONS    = 4;
	localparam logic [2:0] MOD_ID         = 3'd5;
	localparam int         NUM_PKTS       = 7;
	localparam int         NUM_CTRL       = 5;
	localparam int         TIMEOUT_CYCLES = 300 * NUM_PKTS + 50 * NUM_CTRL;

	logic                                clk;
	logic                                aresetn;
	logic [depar_stream_pkg::VLAN_W-1:0] vlan_id;
	logic                                vlan_empty;
	logic                                vlan_rd_en;
	depar_action_pkg::phv_t              phv;
	logic                                phv_empty;
	logic                                phv_rd_en;
	depar_stream_pkg::hdr_data_t         hdr_tdata;
	depar_stream_pkg::hdr_keep_t         hdr_tkeep;
	logic [1:0]                          hdr_tlast;
	logic                                hdr_empty;
	logic                                hdr_rd_en;
	depar_stream_pkg::data_t             pkt_tdata;
	depar_stream_pkg::keep_t             pkt_tkeep;
	logic                                pkt_tlast;
	logic                                pkt_empty;
	logic                                pkt_rd_en;
	depar_stream_pkg::data_t             depar_out_tdata;
	depar_stream_pkg::keep_t             depar_out_tkeep;
	logic                                depar_out_tlast;
	logic                                depar_out_tvalid;
	logic                                depar_out_tready;
	depar_stream_pkg::data_t             ctrl_tdata;
	logic                                ctrl_tvalid;
	logic                                ctrl_tlast;

	// fifo contents with the head at index 0
	logic [11:0]                 vlan_q[$];
	depar_action_pkg::phv_t      phv_q[$];
	depar_stream_pkg::hdr_data_t hdr_data_q[$];
	depar_stream_pkg::hdr_keep_t hdr_keep_q[$];
	logic [1:0]                  hdr_last_q[$];
	depar_stream_pkg::data_t     pkt_data_q[$];
	depar_stream_pkg::keep_t     pkt_keep_q[$];
	logic                        pkt_last_q[$];
	depar_stream_pkg::data_t     exp_data_q[$];
	depar_stream_pkg::keep_t     exp_keep_q[$];
	logic                        exp_last_q[$];

	logic [63:0]                 shadow_tbl [0:31]; // expected table contents
	depar_action_pkg::phv_t      stim_phv;
	depar_stream_pkg::hdr_data_t stim_hdr;
	depar_stream_pkg::hdr_keep_t stim_keep;
	depar_stream_pkg::data_t     pay_data [0:3];
	depar_stream_pkg::keep_t     pay_keep [0:3];
	bit                          bp_on;
	int                          cycle_cnt = 0;

	depar_top #(
		.NUM_ACTIONS (NUM_ACTIONS),
		.MOD_ID      (MOD_ID)
	) depar_top_i (
		.clk              (clk),
		.aresetn          (aresetn),
		.vlan_id          (vlan_id),
		.vlan_empty       (vlan_empty),
		.vlan_rd_en       (vlan_rd_en),
		.phv              (phv),
		.phv_empty        (phv_empty),
		.phv_rd_en        (phv_rd_en),
		.hdr_tdata        (hdr_tdata),
		.hdr_tkeep        (hdr_tkeep),
		.hdr_tlast        (hdr_tlast),
		.hdr_empty        (hdr_empty),
		.hdr_rd_en        (hdr_rd_en),
		.pkt_tdata        (pkt_tdata),
		.pkt_tkeep        (pkt_tkeep),
		.pkt_tlast        (pkt_tlast),
		.pkt_empty        (pkt_empty),
		.pkt_rd_en        (pkt_rd_en),
		.depar_out_tdata  (depar_out_tdata),
		.depar_out_tkeep  (depar_out_tkeep),
		.depar_out_tlast  (depar_out_tlast),
		.depar_out_tvalid (depar_out_tvalid),
		.depar_out_tready (depar_out_tready),
		.ctrl_tdata       (ctrl_tdata),
		.ctrl_tvalid      (ctrl_tvalid),
		.ctrl_tlast       (ctrl_tlast)
	);

	`include "tb_depar_tasks.svh"

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// fwft fifo heads and tready update on the falling edge
	initial begin
		vlan_id          = '0;
		vlan_empty       = 1'b1;
		phv              = '0;
		phv_empty        = 1'b1;
		hdr_tdata        = '0;
		hdr_tkeep        = '0;
		hdr_tlast        = 2'b00;
		hdr_empty        = 1'b1;
		pkt_tdata        = '0;
		pkt_tkeep        = '0;
		pkt_tlast        = 1'b0;
		pkt_empty        = 1'b1;
		depar_out_tready = 1'b1;
		forever begin
			@(negedge clk);
			vlan_empty = (vlan_q.size() == 0);
			vlan_id    = vlan_empty ? '0 : vlan_q[0];
			phv_empty  = (phv_q.size() == 0);
			phv        = phv_empty ? '0 : phv_q[0];
			hdr_empty  = (hdr_data_q.size() == 0);
			hdr_tdata  = hdr_empty ? '0 : hdr_data_q[0];
			hdr_tkeep  = hdr_empty ? '0 : hdr_keep_q[0];
			hdr_tlast  = hdr_empty ? 2'b00 : hdr_last_q[0];
			pkt_empty  = (pkt_data_q.size() == 0);
			pkt_tdata  = pkt_empty ? '0 : pkt_data_q[0];
			pkt_tkeep  = pkt_empty ? '0 : pkt_keep_q[0];
			pkt_tlast  = pkt_empty ? 1'b0 : pkt_last_q[0];
			depar_out_tready = bp_on ? 1'($urandom) : 1'b1;
		end
	end

	always @(posedge clk) begin
		if ((vlan_rd_en && vlan_q.size() == 0) || (phv_rd_en && phv_q.size() == 0) ||
				(hdr_rd_en && hdr_data_q.size() == 0) || (pkt_rd_en && pkt_data_q.size() == 0))
			fail_run("a FIFO was read while empty");
		else
			pop_fifos();
	end

	always @(posedge clk) begin
		if (depar_out_tvalid && depar_out_tready) check_beat();
	end

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt == TIMEOUT_CYCLES)
			fail_run($sformatf("run timed out after %0d cycles", TIMEOUT_CYCLES));
	end

	initial begin
		void'($urandom(32'h2d43_fe6a));
		aresetn     = 1'b0;
		ctrl_tdata  = '0;
		ctrl_tvalid = 1'b0;
		ctrl_tlast  = 1'b0;
		bp_on       = 1'b0;
		for (int i = 0; i < 32; i++) begin
			shadow_tbl[i] = '0;
		end
		repeat (4) @(negedge clk);
		aresetn = 1'b1;
		repeat (2) @(negedge clk);
		test_field_sizes();
		test_unused_foreign();
		test_full_packet();
		test_back_pressure();
		test_back_to_back();
		$display("Finished with no errors");
		$finish;
	end

endmodule
